//--- ooo_pkg.sv
// Shared sizes, tag type and encodings for the out-of-order core
// Imported by every RTL module and the testbench
package ooo_pkg;

    //////////////////////////////
    // Datapath and register file
    //////////////////////////////

    // One machine word
    localparam int XLEN = 32;

    // Architectural registers x0..x31
    localparam int NUM_REGS  = 32;
    localparam int REG_IDX_W = 5;

    // x0 reads as zero, never renamed
    localparam logic [REG_IDX_W-1:0] ZERO_REG = 5'd0;

    //////////////////////////////
    // Window sizes
    //////////////////////////////

    // Reorder buffer, power of two so tags wrap freely
    localparam int ROB_DEPTH = 8;
    localparam int ROB_TAG_W = $clog2(ROB_DEPTH);

    // Reservation station slots
    localparam int RS_DEPTH = 4;
    localparam int RS_IDX_W = $clog2(RS_DEPTH);

    // Reorder buffer index, also the rename tag
    typedef logic [ROB_TAG_W-1:0] rob_tag_t;

    // ALU operations
    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4
    } alu_op_e;

    // RV32I major opcodes that the core accepts
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011
    } rv_opcode_e;

endpackage

//--- inst_decode.sv
// Combinational decoder for the supported RV32I integer subset
// Anything outside ADD/SUB/AND/OR/XOR/ADDI comes out flagged illegal
`timescale 1ns/1ns

module inst_decode
    import ooo_pkg::*;
(
    input  logic [31:0]          inst,
    output alu_op_e              dec_op,
    output logic [REG_IDX_W-1:0] dec_rd,
    output logic [REG_IDX_W-1:0] dec_rs1,
    output logic [REG_IDX_W-1:0] dec_rs2,
    output logic [XLEN-1:0]      dec_imm,
    output logic                 dec_use_imm,
    output logic                 dec_has_dest,
    output logic                 dec_illegal
);

    rv_opcode_e opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    // Fixed RISC-V field positions
    assign opcode  = rv_opcode_e'(inst[6:0]);
    assign funct3  = inst[14:12];
    assign funct7  = inst[31:25];
    assign dec_rd  = inst[11:7];
    assign dec_rs1 = inst[19:15];
    assign dec_rs2 = inst[24:20];

    // I-type immediate, sign extended
    assign dec_imm = {{(XLEN-12){inst[31]}}, inst[31:20]};

    always_comb begin
        dec_op      = ALU_ADD;
        dec_use_imm = 1'b0;
        dec_illegal = 1'b0;
        case (opcode)
            OPC_OP: begin
                // funct7 picks SUB apart from ADD, must be zero elsewhere
                case ({funct7, funct3})
                    {7'b0000000, 3'b000}: dec_op = ALU_ADD;
                    {7'b0100000, 3'b000}: dec_op = ALU_SUB;
                    {7'b0000000, 3'b111}: dec_op = ALU_AND;
                    {7'b0000000, 3'b110}: dec_op = ALU_OR;
                    {7'b0000000, 3'b100}: dec_op = ALU_XOR;
                    default:              dec_illegal = 1'b1;
                endcase
            end
            OPC_OP_IMM: begin
                // Only ADDI from the immediate group
                dec_use_imm = 1'b1;
                dec_illegal = (funct3 != 3'b000);
            end
            default: dec_illegal = 1'b1;
        endcase
    end

    // x0 as target and illegal words write nothing
    assign dec_has_dest = !dec_illegal && (dec_rd != ZERO_REG);

endmodule

//--- register_rename.sv
// Committed register file plus per-register producer tag map
// Dispatch marks rd pending on the new ROB tail, commit writes and clears it
`timescale 1ns/1ns

module register_rename
    import ooo_pkg::*;
(
    input  logic                 clock,
    input  logic                 rst_n,
    input  logic                 dispatch_fire,
    input  logic                 dec_has_dest,
    input  logic [REG_IDX_W-1:0] dec_rd,
    input  logic [REG_IDX_W-1:0] dec_rs1,
    input  logic [REG_IDX_W-1:0] dec_rs2,
    input  rob_tag_t             rob_tail_tag,
    input  logic                 commit_valid,
    input  logic                 commit_wr_en,
    input  logic [REG_IDX_W-1:0] commit_wr_idx,
    input  logic [XLEN-1:0]      commit_wr_data,
    input  rob_tag_t             commit_tag,
    output logic                 src1_pending,
    output logic                 src2_pending,
    output rob_tag_t             src1_tag,
    output rob_tag_t             src2_tag,
    output logic [XLEN-1:0]      src1_arch_value,
    output logic [XLEN-1:0]      src2_arch_value
);

    logic [XLEN-1:0]     arch_regs [NUM_REGS];
    logic [NUM_REGS-1:0] pending;
    rob_tag_t            map_tag   [NUM_REGS];

    // Source lookups see the state before this cycle's dispatch
    assign src1_pending    = pending[dec_rs1];
    assign src2_pending    = pending[dec_rs2];
    assign src1_tag        = map_tag[dec_rs1];
    assign src2_tag        = map_tag[dec_rs2];
    assign src1_arch_value = arch_regs[dec_rs1];
    assign src2_arch_value = arch_regs[dec_rs2];

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            pending <= '0;
            for (int i = 0; i < NUM_REGS; i++) begin
                arch_regs[i] <= '0;
            end
        end else begin
            if (commit_valid && commit_wr_en) begin
                arch_regs[commit_wr_idx] <= commit_wr_data;
                // A younger producer may own the register by now
                if (pending[commit_wr_idx] && map_tag[commit_wr_idx] == commit_tag) begin
                    pending[commit_wr_idx] <= 1'b0;
                end
            end
            // New producer wins over a same-cycle commit
            if (dispatch_fire && dec_has_dest) begin
                pending[dec_rd] <= 1'b1;
            end
        end
    end

    // Youngest in-flight producer of each register
    always_ff @(posedge clock) begin
        if (dispatch_fire && dec_has_dest) begin
            map_tag[dec_rd] <= rob_tail_tag;
        end
    end

endmodule

//--- reorder_buffer.sv
// Circular reorder buffer filled at dispatch and completed from the CDB
// Retires the head in order, one per cycle, and answers operand lookups
`timescale 1ns/1ns

module reorder_buffer
    import ooo_pkg::*;
(
    input  logic                 clock,
    input  logic                 rst_n,
    input  logic                 dispatch_fire,
    input  logic                 dec_has_dest,
    input  logic                 dec_illegal,
    input  logic [REG_IDX_W-1:0] dec_rd,
    input  logic                 cdb_valid,
    input  rob_tag_t             cdb_tag,
    input  logic [XLEN-1:0]      cdb_value,
    input  rob_tag_t             lookup1_tag,
    input  rob_tag_t             lookup2_tag,
    output logic                 lookup1_done,
    output logic                 lookup2_done,
    output logic [XLEN-1:0]      lookup1_value,
    output logic [XLEN-1:0]      lookup2_value,
    output rob_tag_t             rob_tail_tag,
    output logic                 rob_full,
    output logic                 commit_valid,
    output logic                 commit_wr_en,
    output logic                 commit_illegal,
    output logic [REG_IDX_W-1:0] commit_wr_idx,
    output logic [XLEN-1:0]      commit_wr_data,
    output rob_tag_t             commit_tag
);

    //////////////////////////////
    // Entry state
    //////////////////////////////

    logic [ROB_DEPTH-1:0] ent_valid;
    logic [ROB_DEPTH-1:0] ent_done;
    logic [ROB_DEPTH-1:0] ent_has_dest;
    logic [ROB_DEPTH-1:0] ent_illegal;
    logic [REG_IDX_W-1:0] ent_rd    [ROB_DEPTH];
    logic [XLEN-1:0]      ent_value [ROB_DEPTH];
    rob_tag_t             head;
    rob_tag_t             tail;

    // Tail caught up with a live head means no free slot
    assign rob_tail_tag = tail;
    assign rob_full     = ent_valid[tail];

    // Operand lookups for the RS
    assign lookup1_done  = ent_valid[lookup1_tag] && ent_done[lookup1_tag];
    assign lookup2_done  = ent_valid[lookup2_tag] && ent_done[lookup2_tag];
    assign lookup1_value = ent_value[lookup1_tag];
    assign lookup2_value = ent_value[lookup2_tag];

    // Head retires once its result is in
    assign commit_valid   = ent_valid[head] && ent_done[head];
    assign commit_wr_en   = commit_valid && ent_has_dest[head];
    assign commit_illegal = commit_valid && ent_illegal[head];
    assign commit_wr_idx  = ent_rd[head];
    assign commit_wr_data = ent_value[head];
    assign commit_tag     = head;

    //////////////////////////////
    // Allocate, complete, retire
    //////////////////////////////

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            ent_valid <= '0;
            ent_done  <= '0;
            head      <= '0;
            tail      <= '0;
        end else begin
            if (cdb_valid) begin
                ent_done[cdb_tag] <= 1'b1;
            end
            // Illegal words have nothing to execute and start out done
            if (dispatch_fire) begin
                ent_valid[tail] <= 1'b1;
                ent_done[tail]  <= dec_illegal;
                tail            <= tail + 1'b1;
            end
            if (commit_valid) begin
                ent_valid[head] <= 1'b0;
                head            <= head + 1'b1;
            end
        end
    end

    // Entry payload and results from the CDB
    always_ff @(posedge clock) begin
        if (dispatch_fire) begin
            ent_has_dest[tail] <= dec_has_dest;
            ent_illegal[tail]  <= dec_illegal;
            ent_rd[tail]       <= dec_rd;
        end
        if (cdb_valid) begin
            ent_value[cdb_tag] <= cdb_value;
        end
    end

endmodule

//--- reservation_station.sv
// Reservation station holding dispatched ops until both operands are known
// Snoops the CDB and issues the oldest ready entry to the ALU each cycle
`timescale 1ns/1ns

module reservation_station
    import ooo_pkg::*;
(
    input  logic            clock,
    input  logic            rst_n,
    input  logic            dispatch_fire,
    input  logic            dec_illegal,
    input  alu_op_e         dec_op,
    input  logic [XLEN-1:0] dec_imm,
    input  logic            dec_use_imm,
    input  rob_tag_t        rob_tail_tag,
    input  logic            src1_pending,
    input  logic            src2_pending,
    input  rob_tag_t        src1_tag,
    input  rob_tag_t        src2_tag,
    input  logic [XLEN-1:0] src1_arch_value,
    input  logic [XLEN-1:0] src2_arch_value,
    input  logic            lookup1_done,
    input  logic            lookup2_done,
    input  logic [XLEN-1:0] lookup1_value,
    input  logic [XLEN-1:0] lookup2_value,
    input  logic            cdb_valid,
    input  rob_tag_t        cdb_tag,
    input  logic [XLEN-1:0] cdb_value,
    output logic            rs_full,
    output logic            issue_valid,
    output alu_op_e         issue_op,
    output logic [XLEN-1:0] issue_a,
    output logic [XLEN-1:0] issue_b,
    output rob_tag_t        issue_tag
);

    logic [RS_DEPTH-1:0] ent_valid, ent_rdy1, ent_rdy2;
    logic [RS_DEPTH-1:0] cap1, cap2;
    logic [RS_IDX_W-1:0] ent_age [RS_DEPTH];
    alu_op_e             ent_op  [RS_DEPTH];
    logic [XLEN-1:0]     ent_v1  [RS_DEPTH];
    logic [XLEN-1:0]     ent_v2  [RS_DEPTH];
    rob_tag_t            ent_t1  [RS_DEPTH];
    rob_tag_t            ent_t2  [RS_DEPTH];
    rob_tag_t            ent_tag [RS_DEPTH];

    logic                alloc_fire, issue_fire;
    logic [RS_IDX_W-1:0] alloc_idx, issue_idx;
    logic [RS_IDX_W:0]   occupied, new_age;
    logic [XLEN:0]       op1, op2;

    // Ready/value for one source: arch file, finished ROB entry or live CDB
    function automatic logic [XLEN:0] resolve(
        input logic pending, input rob_tag_t tag, input logic [XLEN-1:0] arch,
        input logic rob_done, input logic [XLEN-1:0] rob_value,
        input logic bus_valid, input rob_tag_t bus_tag, input logic [XLEN-1:0] bus_value
    );
        if (!pending) return {1'b1, arch};
        if (rob_done) return {1'b1, rob_value};
        if (bus_valid && bus_tag == tag) return {1'b1, bus_value};
        return {1'b0, arch};
    endfunction

    // Bit XLEN is the ready flag
    assign op1 = resolve(src1_pending, src1_tag, src1_arch_value, lookup1_done,
                         lookup1_value, cdb_valid, cdb_tag, cdb_value);
    // ADDI takes the immediate in place of rs2
    assign op2 = dec_use_imm ? {1'b1, dec_imm}
               : resolve(src2_pending, src2_tag, src2_arch_value, lookup2_done,
                         lookup2_value, cdb_valid, cdb_tag, cdb_value);

    // Illegal words skip the RS, the ROB completes them alone
    assign alloc_fire = dispatch_fire && !dec_illegal;
    assign rs_full    = &ent_valid;

    always_comb begin
        alloc_idx  = '0;
        issue_idx  = '0;
        issue_fire = 1'b0;
        occupied   = '0;
        for (int i = RS_DEPTH - 1; i >= 0; i--) begin
            if (!ent_valid[i]) alloc_idx = RS_IDX_W'(i);
            occupied = occupied + ent_valid[i];
            cap1[i] = ent_valid[i] && !ent_rdy1[i] && cdb_valid && cdb_tag == ent_t1[i];
            cap2[i] = ent_valid[i] && !ent_rdy2[i] && cdb_valid && cdb_tag == ent_t2[i];
        end
        // Lowest age is the oldest waiting entry
        for (int i = 0; i < RS_DEPTH; i++) begin
            if (ent_valid[i] && ent_rdy1[i] && ent_rdy2[i] &&
                (!issue_fire || ent_age[i] < ent_age[issue_idx])) begin
                issue_fire = 1'b1;
                issue_idx  = RS_IDX_W'(i);
            end
        end
        // Newcomer ranks behind whatever stays
        new_age = occupied - {{RS_IDX_W{1'b0}}, issue_fire};
    end

    assign issue_valid = issue_fire;
    assign issue_op    = ent_op[issue_idx];
    assign issue_a     = ent_v1[issue_idx];
    assign issue_b     = ent_v2[issue_idx];
    assign issue_tag   = ent_tag[issue_idx];

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            ent_valid <= '0;
            ent_rdy1  <= '0;
            ent_rdy2  <= '0;
            for (int i = 0; i < RS_DEPTH; i++) ent_age[i] <= '0;
        end else begin
            for (int i = 0; i < RS_DEPTH; i++) begin
                if (cap1[i]) ent_rdy1[i] <= 1'b1;
                if (cap2[i]) ent_rdy2[i] <= 1'b1;
                // Younger entries move up when one leaves
                if (issue_fire && issue_idx == RS_IDX_W'(i)) begin
                    ent_valid[i] <= 1'b0;
                end else if (issue_fire && ent_age[i] > ent_age[issue_idx]) begin
                    ent_age[i] <= ent_age[i] - 1'b1;
                end
            end
            if (alloc_fire) begin
                ent_valid[alloc_idx] <= 1'b1;
                ent_rdy1[alloc_idx]  <= op1[XLEN];
                ent_rdy2[alloc_idx]  <= op2[XLEN];
                ent_age[alloc_idx]   <= new_age[RS_IDX_W-1:0];
            end
        end
    end

    // Operand payload and tags
    always_ff @(posedge clock) begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            if (cap1[i]) ent_v1[i] <= cdb_value;
            if (cap2[i]) ent_v2[i] <= cdb_value;
        end
        if (alloc_fire) begin
            ent_op[alloc_idx]  <= dec_op;
            ent_v1[alloc_idx]  <= op1[XLEN-1:0];
            ent_v2[alloc_idx]  <= op2[XLEN-1:0];
            ent_t1[alloc_idx]  <= src1_tag;
            ent_t2[alloc_idx]  <= src2_tag;
            ent_tag[alloc_idx] <= rob_tail_tag;
        end
    end

endmodule

//--- alu_unit.sv
// Single integer ALU with a registered result
// Its output register is the common data bus, one broadcast per cycle
`timescale 1ns/1ns

module alu_unit
    import ooo_pkg::*;
(
    input  logic            clock,
    input  logic            rst_n,
    input  logic            issue_valid,
    input  alu_op_e         issue_op,
    input  logic [XLEN-1:0] issue_a,
    input  logic [XLEN-1:0] issue_b,
    input  rob_tag_t        issue_tag,
    output logic            cdb_valid,
    output rob_tag_t        cdb_tag,
    output logic [XLEN-1:0] cdb_value
);

    logic [XLEN-1:0] result;

    always_comb begin
        case (issue_op)
            ALU_ADD: result = issue_a + issue_b;
            ALU_SUB: result = issue_a - issue_b;
            ALU_AND: result = issue_a & issue_b;
            ALU_OR:  result = issue_a | issue_b;
            ALU_XOR: result = issue_a ^ issue_b;
            default: result = '0;
        endcase
    end

    // Broadcast one cycle after issue
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            cdb_valid <= 1'b0;
        end else begin
            cdb_valid <= issue_valid;
        end
    end

    always_ff @(posedge clock) begin
        if (issue_valid) begin
            cdb_tag   <= issue_tag;
            cdb_value <= result;
        end
    end

endmodule

//--- ooo_core.sv
// Top of the out-of-order core: decode, rename, RS, ALU/CDB and ROB
// Takes one instruction per cycle and reports in-order commits
`timescale 1ns/1ns

module ooo_core
    import ooo_pkg::*;
(
    input  logic                 clock,
    input  logic                 rst_n,
    input  logic                 inst_valid,
    input  logic [31:0]          inst,
    output logic                 dispatch_stall,
    output logic                 commit_valid,
    output logic                 commit_wr_en,
    output logic                 commit_illegal,
    output logic [REG_IDX_W-1:0] commit_wr_idx,
    output logic [XLEN-1:0]      commit_wr_data
);

    alu_op_e              dec_op;
    logic [REG_IDX_W-1:0] dec_rd, dec_rs1, dec_rs2;
    logic [XLEN-1:0]      dec_imm;
    logic                 dec_use_imm, dec_has_dest, dec_illegal;

    logic                 src1_pending, src2_pending;
    rob_tag_t             src1_tag, src2_tag;
    logic [XLEN-1:0]      src1_arch_value, src2_arch_value;

    logic                 lookup1_done, lookup2_done;
    logic [XLEN-1:0]      lookup1_value, lookup2_value;
    rob_tag_t             rob_tail_tag, commit_tag;
    logic                 rob_full, rs_full, dispatch_fire;

    logic                 issue_valid, cdb_valid;
    alu_op_e              issue_op;
    logic [XLEN-1:0]      issue_a, issue_b, cdb_value;
    rob_tag_t             issue_tag, cdb_tag;

    //////////////////////////////
    // Dispatch enable
    //////////////////////////////

    // Illegal words need a ROB slot only
    assign dispatch_stall = rob_full || (rs_full && !dec_illegal);
    assign dispatch_fire  = inst_valid && !dispatch_stall;

    inst_decode u_decode (
        .inst(inst), .dec_op(dec_op),
        .dec_rd(dec_rd), .dec_rs1(dec_rs1), .dec_rs2(dec_rs2),
        .dec_imm(dec_imm), .dec_use_imm(dec_use_imm),
        .dec_has_dest(dec_has_dest), .dec_illegal(dec_illegal)
    );

    register_rename u_rename (
        .clock(clock), .rst_n(rst_n),
        .dispatch_fire(dispatch_fire), .dec_has_dest(dec_has_dest),
        .dec_rd(dec_rd), .dec_rs1(dec_rs1), .dec_rs2(dec_rs2),
        .rob_tail_tag(rob_tail_tag),
        .commit_valid(commit_valid), .commit_wr_en(commit_wr_en),
        .commit_wr_idx(commit_wr_idx), .commit_wr_data(commit_wr_data),
        .commit_tag(commit_tag),
        .src1_pending(src1_pending), .src2_pending(src2_pending),
        .src1_tag(src1_tag), .src2_tag(src2_tag),
        .src1_arch_value(src1_arch_value), .src2_arch_value(src2_arch_value)
    );

    // Lookups follow the rename tags of the current sources
    reorder_buffer u_rob (
        .clock(clock), .rst_n(rst_n),
        .dispatch_fire(dispatch_fire), .dec_has_dest(dec_has_dest),
        .dec_illegal(dec_illegal), .dec_rd(dec_rd),
        .cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_value(cdb_value),
        .lookup1_tag(src1_tag), .lookup2_tag(src2_tag),
        .lookup1_done(lookup1_done), .lookup2_done(lookup2_done),
        .lookup1_value(lookup1_value), .lookup2_value(lookup2_value),
        .rob_tail_tag(rob_tail_tag), .rob_full(rob_full),
        .commit_valid(commit_valid), .commit_wr_en(commit_wr_en),
        .commit_illegal(commit_illegal), .commit_wr_idx(commit_wr_idx),
        .commit_wr_data(commit_wr_data), .commit_tag(commit_tag)
    );

    reservation_station u_rs (
        .clock(clock), .rst_n(rst_n),
        .dispatch_fire(dispatch_fire), .dec_illegal(dec_illegal),
        .dec_op(dec_op), .dec_imm(dec_imm), .dec_use_imm(dec_use_imm),
        .rob_tail_tag(rob_tail_tag),
        .src1_pending(src1_pending), .src2_pending(src2_pending),
        .src1_tag(src1_tag), .src2_tag(src2_tag),
        .src1_arch_value(src1_arch_value), .src2_arch_value(src2_arch_value),
        .lookup1_done(lookup1_done), .lookup2_done(lookup2_done),
        .lookup1_value(lookup1_value), .lookup2_value(lookup2_value),
        .cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_value(cdb_value),
        .rs_full(rs_full),
        .issue_valid(issue_valid), .issue_op(issue_op),
        .issue_a(issue_a), .issue_b(issue_b), .issue_tag(issue_tag)
    );

    alu_unit u_alu (
        .clock(clock), .rst_n(rst_n),
        .issue_valid(issue_valid), .issue_op(issue_op),
        .issue_a(issue_a), .issue_b(issue_b), .issue_tag(issue_tag),
        .cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_value(cdb_value)
    );

endmodule

//--- tb_ooo_core.sv
// Testbench for the out-of-order core, program and expected commits from ooo_cases.txt
// Each case row is also replayed on a sequential register model before the run
`timescale 1ns/1ns

module tb_ooo_core
    import ooo_pkg::*;
();

    localparam int MAX_CASES  = 64;
    localparam int CLK_HALF   = 4;
    localparam int BURST_TEST = 6;

    logic                 clock;
    logic                 rst_n;
    logic                 inst_valid;
    logic [31:0]          inst;
    logic                 dispatch_stall;
    logic                 commit_valid;
    logic                 commit_wr_en;
    logic                 commit_illegal;
    logic [REG_IDX_W-1:0] commit_wr_idx;
    logic [XLEN-1:0]      commit_wr_data;

    // Raw file image, count word then four words per case
    logic [31:0] case_mem [0:4*MAX_CASES];

    int          n_cases;
    logic [7:0]  case_test [MAX_CASES];
    logic [7:0]  case_gap  [MAX_CASES];
    logic [31:0] case_inst [MAX_CASES];
    logic        exp_ill   [MAX_CASES];
    logic        exp_wen   [MAX_CASES];
    logic [4:0]  exp_idx   [MAX_CASES];
    logic [31:0] exp_data  [MAX_CASES];

    logic [XLEN-1:0] model_regs [NUM_REGS];
    int     commits_seen;
    int     cycle_count;
    int     cycle_limit;
    int     errors;
    int     tests_run;
    int     tests_failed;
    int     cur_test;
    int     test_errors [8];
    int     test_stalls [8];
    integer seed;

    initial begin
        clock = 1'b0;
        forever #CLK_HALF clock = ~clock;
    end

    ooo_core UUT (
        .clock(clock), .rst_n(rst_n),
        .inst_valid(inst_valid), .inst(inst),
        .dispatch_stall(dispatch_stall),
        .commit_valid(commit_valid), .commit_wr_en(commit_wr_en),
        .commit_illegal(commit_illegal), .commit_wr_idx(commit_wr_idx),
        .commit_wr_data(commit_wr_data)
    );

    //////////////////////////////
    // Reference model and case file
    //////////////////////////////

    // One instruction in program order, straight from the RV32I encoding
    task automatic model_step(input logic [31:0] word, output logic ill,
                              output logic wen, output logic [4:0] rd,
                              output logic [31:0] value);
        logic [31:0] a;
        logic [31:0] b;
        a     = model_regs[word[19:15]];
        b     = model_regs[word[24:20]];
        rd    = word[11:7];
        ill   = 1'b0;
        value = 32'h0;
        if (word[6:0] == 7'h13 && word[14:12] == 3'b000) begin
            value = a + {{20{word[31]}}, word[31:20]};
        end else if (word[6:0] == 7'h33) begin
            case ({word[31:25], word[14:12]})
                {7'h00, 3'b000}: value = a + b;
                {7'h20, 3'b000}: value = a - b;
                {7'h00, 3'b111}: value = a & b;
                {7'h00, 3'b110}: value = a | b;
                {7'h00, 3'b100}: value = a ^ b;
                default:         ill = 1'b1;
            endcase
        end else begin
            ill = 1'b1;
        end
        wen = !ill && rd != 5'd0;
        if (wen) model_regs[rd] = value;
    endtask

    task automatic load_cases();
        logic        m_ill;
        logic        m_wen;
        logic [4:0]  m_rd;
        logic [31:0] m_val;
        logic [31:0] ctl;
        logic [31:0] expw;
        $readmemh("ooo_cases.txt", case_mem);
        n_cases = int'(case_mem[0]);
        if (n_cases > MAX_CASES) begin
            $display("Case file holds %0d cases, more than the %0d supported", n_cases, MAX_CASES);
            errors++;
            n_cases = MAX_CASES;
        end
        for (int r = 0; r < NUM_REGS; r++) model_regs[r] = '0;
        for (int k = 0; k < n_cases; k++) begin
            ctl          = case_mem[1 + 4*k];
            expw         = case_mem[3 + 4*k];
            case_test[k] = ctl[15:8];
            case_gap[k]  = ctl[7:0];
            case_inst[k] = case_mem[2 + 4*k];
            exp_ill[k]   = expw[12];
            exp_wen[k]   = expw[8];
            exp_idx[k]   = expw[4:0];
            exp_data[k]  = case_mem[4 + 4*k];
            model_step(case_inst[k], m_ill, m_wen, m_rd, m_val);
            // Index and data only count when a register is written
            assert (m_ill == exp_ill[k] && m_wen == exp_wen[k] &&
                    (!m_wen || (m_rd == exp_idx[k] && m_val == exp_data[k])))
            else begin
                $display("Case row %0d disagrees with the reference model", k);
                errors++;
            end
        end
    endtask

    function automatic string test_name(input int id);
        case (id)
            1:       return "reset state";
            2:       return "alu ops";
            3:       return "raw chains";
            4:       return "x0 writes";
            5:       return "illegal words";
            6:       return "back-pressure";
            default: return "other";
        endcase
    endfunction

    //////////////////////////////
    // Stimulus
    //////////////////////////////

    // Random idle gap, then hold the word until a rising edge sees no stall
    task automatic send_case(input int k);
        int gap;
        gap = 0;
        if (case_gap[k] != 8'd0) begin
            gap = int'($unsigned($random(seed)) % (int'(case_gap[k]) + 1));
        end
        repeat (gap) begin
            @(negedge clock);
            inst_valid = 1'b0;
        end
        @(negedge clock);
        cur_test   = int'(case_test[k]);
        inst_valid = 1'b1;
        inst       = case_inst[k];
        @(posedge clock);
        while (dispatch_stall) @(posedge clock);
    endtask

    //////////////////////////////
    // Commit checks
    //////////////////////////////

    task automatic report_mismatch(input int k, input string what,
                                   input logic [31:0] got, input logic [31:0] want);
        $display("FAIL %0t: case %0d (test %0d) %s is %h, expected %h",
                 $time, k, case_test[k], what, got, want);
        errors++;
        test_errors[case_test[k]]++;
    endtask

    task automatic finish_test(input int id);
        if (id == BURST_TEST) begin
            assert (test_stalls[id] > 0) else begin
                $display("Burst test never saw dispatch_stall go high");
                errors++;
                test_errors[id]++;
            end
        end
        tests_run++;
        if (test_errors[id] != 0) tests_failed++;
        $display("test %0d %-14s %s, %0d errors", id, test_name(id),
                 (test_errors[id] == 0) ? "ok" : "FAILED", test_errors[id]);
    endtask

    task automatic check_commit();
        int k;
        k = commits_seen;
        assert (k < n_cases) else begin
            $display("Extra commit at %0t after the last instruction", $time);
            errors++;
        end
        if (k < n_cases) begin
            assert (commit_illegal == exp_ill[k])
                else report_mismatch(k, "commit_illegal", commit_illegal, exp_ill[k]);
            assert (commit_wr_en == exp_wen[k])
                else report_mismatch(k, "commit_wr_en", commit_wr_en, exp_wen[k]);
            if (exp_wen[k]) begin
                assert (commit_wr_idx == exp_idx[k])
                    else report_mismatch(k, "commit_wr_idx", commit_wr_idx, exp_idx[k]);
                assert (commit_wr_data == exp_data[k])
                    else report_mismatch(k, "commit_wr_data", commit_wr_data, exp_data[k]);
            end
            commits_seen++;
            if (k == n_cases - 1 || case_test[k + 1] != case_test[k]) begin
                finish_test(int'(case_test[k]));
            end
        end
    endtask

    // Outputs sampled at the rising edge, before the DUT registers move
    always @(posedge clock) begin
        if (rst_n) begin
            if (inst_valid && dispatch_stall) test_stalls[cur_test]++;
            if (commit_valid) check_commit();
        end
    end

    // Cycle budget for the whole program
    always @(posedge clock) begin
        if (rst_n) cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("Timeout after %0d cycles with %0d of %0d commits seen",
                     cycle_count, commits_seen, n_cases);
            $display("Test failed");
            $finish;
        end
    end

    //////////////////////////////
    // Main sequence
    //////////////////////////////

    initial begin
        seed         = 32'h324aa130;
        rst_n        = 1'b0;
        inst_valid   = 1'b0;
        inst         = 32'h0;
        errors       = 0;
        commits_seen = 0;
        cycle_count  = 0;
        tests_run    = 0;
        tests_failed = 0;
        cur_test     = 1;
        for (int t = 0; t < 8; t++) begin
            test_errors[t] = 0;
            test_stalls[t] = 0;
        end
        load_cases();
        cycle_limit = 20 * n_cases + 100;
        repeat (4) @(posedge clock);
        @(negedge clock);
        rst_n = 1'b1;

        // Idle core, nothing sent yet
        repeat (5) begin
            @(posedge clock);
            assert (!commit_valid && !dispatch_stall) else begin
                $display("FAIL %0t: idle core shows commit_valid %b dispatch_stall %b",
                         $time, commit_valid, dispatch_stall);
                errors++;
                test_errors[1]++;
            end
        end
        finish_test(1);

        for (int k = 0; k < n_cases; k++) begin
            send_case(k);
        end
        @(negedge clock);
        inst_valid = 1'b0;
        wait (commits_seen >= n_cases);
        // A few more edges to catch a stray commit
        repeat (5) @(posedge clock);

        $display("Summary: %0d tests, %0d failed, %0d of %0d commits, %0d errors",
                 tests_run, tests_failed, commits_seen, n_cases, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- ooo_core.f
ooo_pkg.sv
inst_decode.sv
register_rename.sv
reorder_buffer.sv
reservation_station.sv
alu_unit.sv
ooo_core.sv
tb_ooo_core.sv

//--- Makefile
# Verilator lint and simulation for the out-of-order core
TB = tb_ooo_core

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -Wall -Wno-fatal -f ooo_core.f --top-module ooo_core

sim:
	verilator --binary --timing --assert -Wno-fatal -f ooo_core.f --top-module $(TB) -o V$(TB)
	out="$$(./obj_dir/V$(TB))"; echo "$$out"; echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf obj_dir

//--- ooo_cases.txt
// First word is the number of cases, then one case per line:
// TTGG (test id, max gap cycles)  instruction  IWRR (illegal, wr_en, rd)  data
0000001D
// Test 2, every ALU operation and ADDI
0203 06400093 0101 00000064
0203 FF900113 0102 FFFFFFF9
0203 002081B3 0103 0000005D
0203 40208233 0104 0000006B
0203 0020F2B3 0105 00000060
0203 0020E333 0106 FFFFFFFD
0203 0020C3B3 0107 FFFFFF9D
// Test 3, back-to-back RAW chain with an independent op behind it
0300 00108413 0108 00000065
0300 00840433 0108 000000CA
0300 401404B3 0109 00000066
0300 0084C533 010A 000000AC
0300 00500593 010B 00000005
0300 00B50633 010C 000000B1
// Test 4, rd of x0 and a read of x0
0402 00308013 0000 00000000
0402 001006B3 010D 00000064
// Test 5, unknown opcode, MUL, then a normal op
0502 FFFFFFFF 1000 00000000
0502 02208733 1000 00000000
0502 0041E733 010E 0000007F
// Test 6, eleven ops with no gaps on one chain
0600 00178793 010F 00000001
0600 00178793 010F 00000002
0600 00178793 010F 00000003
0600 00178793 010F 00000004
0600 00178793 010F 00000005
0600 00178793 010F 00000006
0600 00178793 010F 00000007
0600 00178793 010F 00000008
0600 00178793 010F 00000009
0600 00178793 010F 0000000A
0600 00D78833 0110 0000006E
